// ==== verilog/menu_pkg.sv ====
package menu_pkg;

	// Port number and port data share one width
	typedef logic [7:0] port_t;

	////////////////////////////////////////
	// Write ports
	////////////////////////////////////////
	// Mode select
	localparam port_t PORT_STATE = 8'h0B;
	// Play slot select
	localparam port_t PORT_FILE = 8'h0C;
	// Volume step
	localparam port_t PORT_VOL = 8'h04;
	// Record start or stop
	localparam port_t PORT_RECORD = 8'h05;

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	localparam port_t PORT_SWITCHES = 8'h00;
	localparam port_t PORT_SELECT = 8'h08;
	localparam port_t PORT_BACK = 8'h09;
	localparam port_t PORT_PAUSE = 8'h0A;
	// Same number as PORT_STATE, read side
	localparam port_t PORT_MESSAGES = 8'h0B;

	// Menu modes, codes as written by the processor
	typedef enum logic [2:0] {
		MAIN   = 3'd0,
		PLAY   = 3'd1,
		RECORD = 3'd2,
		DELONE = 3'd3,
		DELALL = 3'd4,
		VOL    = 3'd5
	} menu_mode_e;

	// Volume level and its limits
	typedef logic [3:0] volume_t;
	localparam volume_t VOL_MIN = 4'd1;
	localparam volume_t VOL_MAX = 4'd15;
	localparam volume_t VOL_RESET = 4'd1;

	// Data codes on the volume and record ports
	localparam port_t VOL_UP_CODE = 8'h01;
	localparam port_t VOL_DOWN_CODE = 8'h02;
	localparam port_t REC_STOP_CODE = 8'h00;

endpackage

// ==== verilog/memory_pkg.sv ====
package memory_pkg;

	////////////////////////////////////////
	// RAM word port
	////////////////////////////////////////
	localparam int ADDR_W = 26;
	localparam int SAMPLE_W = 16;

	// Word address into the external RAM
	typedef logic [ADDR_W-1:0] ram_addr_t;
	// One audio sample, one RAM word
	typedef logic [SAMPLE_W-1:0] sample_t;

	////////////////////////////////////////
	// Message slots
	////////////////////////////////////////
	localparam int NUM_SLOTS = 5;
	// Five equal slots over the full address space
	localparam int SLOT_WORDS_DEFAULT = (2 ** ADDR_W) / NUM_SLOTS;

	// Slot index, only 0 to 4 are valid
	typedef logic [2:0] slot_t;
	// One flag per slot, set once something was recorded there
	typedef logic [NUM_SLOTS-1:0] slot_flags_t;

	// Sequencer states
	// Playback walks READ_REQ, READ_WAIT, READ_ACK per word
	// Recording walks REC_WAIT, REC_WRITE per sample
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		READ_REQ  = 3'd1,
		READ_WAIT = 3'd2,
		READ_ACK  = 3'd3,
		REC_WAIT  = 3'd4,
		REC_WRITE = 3'd5
	} seq_state_e;

endpackage

// ==== verilog/pb_write_if.sv ====
`timescale 1ns/1ps

// Decoded processor writes, one strobe per write port
interface pb_write_if import menu_pkg::*; ();

	// Single cycle strobes, high with write_strobe on the matching port
	logic state_wr;
	logic file_wr;
	logic vol_wr;
	logic rec_wr;
	// Processor out_port, valid with any strobe
	port_t data;

	modport decoder (
		output state_wr, file_wr, vol_wr, rec_wr, data
	);

	modport registers (
		input state_wr, file_wr, vol_wr, rec_wr, data
	);

endinterface

// ==== verilog/cmd_if.sv ====
`timescale 1ns/1ps

// Start and stop commands from the menu registers to the sequencer
interface cmd_if import memory_pkg::*; ();

	// Start playback of slot
	logic play_start;
	// Start recording into slot
	logic rec_start;
	// Abort whatever the sequencer is doing
	logic stop;
	// Target slot, valid with either start pulse
	slot_t slot;

	modport registers (
		output play_start, rec_start, stop, slot
	);

	modport sequencer (
		input play_start, rec_start, stop, slot
	);

endinterface

// ==== verilog/port_decoder.sv ====
`timescale 1ns/1ps

module port_decoder import menu_pkg::*, memory_pkg::*; (
	input  logic        clk,
	input  logic        pb_reset,
	// Processor bus
	input  port_t       port_id,
	input  port_t       out_port,
	input  logic        write_strobe,
	output port_t       in_port,
	// Panel inputs
	input  logic [5:0]  switches,
	input  logic        select,
	input  logic        back,
	input  logic        pause_play,
	// Recorded slots
	input  slot_flags_t message_flags,
	pb_write_if.decoder wr
);

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	// Strobes follow write_strobe in the same cycle
	assign wr.state_wr = write_strobe && (port_id == PORT_STATE);
	assign wr.file_wr = write_strobe && (port_id == PORT_FILE);
	assign wr.vol_wr = write_strobe && (port_id == PORT_VOL);
	assign wr.rec_wr = write_strobe && (port_id == PORT_RECORD);
	// Data goes straight through, the strobes qualify it
	assign wr.data = out_port;

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	// Registered mux, in_port settles one cycle after port_id
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= '0;
		end else begin
			case (port_id)
				PORT_SWITCHES: in_port <= port_t'(switches);
				// Single buttons sit in bit 0
				PORT_SELECT:   in_port <= port_t'(select);
				PORT_BACK:     in_port <= port_t'(back);
				PORT_PAUSE:    in_port <= port_t'(pause_play);
				// One bit per slot, slot 0 in bit 0
				PORT_MESSAGES: in_port <= port_t'(message_flags);
				// Unknown ports read as zero
				default:       in_port <= '0;
			endcase
		end
	end

endmodule

// ==== verilog/menu_registers.sv ====
`timescale 1ns/1ps

module menu_registers import menu_pkg::*, memory_pkg::*; (
	input  logic          clk,
	input  logic          pb_reset,
	pb_write_if.registers wr,
	output volume_t       volume_level,
	cmd_if.registers      cmd
);

	menu_mode_e mode;

	// Decoded command conditions, checked against the current mode
	logic play_hit;
	logic rec_hit;
	logic rec_stop_hit;
	logic vol_up_hit;
	logic vol_down_hit;

	// Play takes slot 0 to 4 directly
	assign play_hit = wr.file_wr && (mode == PLAY) && (wr.data < NUM_SLOTS);
	// Record takes slot 1 to 5, zero is the stop code
	assign rec_hit = wr.rec_wr && (mode == RECORD) && (wr.data >= 1) && (wr.data <= NUM_SLOTS);
	assign rec_stop_hit = wr.rec_wr && (mode == RECORD) && (wr.data == REC_STOP_CODE);
	// Volume only moves in VOL mode and never past the limits
	assign vol_up_hit = wr.vol_wr && (mode == VOL) && (wr.data == VOL_UP_CODE)
		&& (volume_level != VOL_MAX);
	assign vol_down_hit = wr.vol_wr && (mode == VOL) && (wr.data == VOL_DOWN_CODE)
		&& (volume_level != VOL_MIN);

	////////////////////////////////////////
	// Mode and volume
	////////////////////////////////////////

	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			mode <= MAIN;
			volume_level <= VOL_RESET;
		end else begin
			// Codes above VOL leave the mode alone
			if (wr.state_wr && (wr.data <= port_t'(VOL)))
				mode <= menu_mode_e'(wr.data[2:0]);
			// One step per write
			if (vol_up_hit)
				volume_level <= volume_level + 4'd1;
			else if (vol_down_hit)
				volume_level <= volume_level - 4'd1;
		end
	end

	////////////////////////////////////////
	// Command pulses
	////////////////////////////////////////

	// Each pulse lasts one cycle, the cycle after the write
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			cmd.play_start <= 1'b0;
			cmd.rec_start <= 1'b0;
			cmd.stop <= 1'b0;
		end else begin
			cmd.play_start <= play_hit;
			cmd.rec_start <= rec_hit;
			// Any mode change aborts playback or recording
			cmd.stop <= wr.state_wr || rec_stop_hit;
		end
	end

	// Slot index rides along with the start pulses
	always_ff @(posedge clk) begin
		if (play_hit)
			cmd.slot <= slot_t'(wr.data);
		else if (rec_hit)
			cmd.slot <= slot_t'(wr.data - 8'd1);
	end

endmodule

// ==== verilog/audio_sequencer.sv ====
`timescale 1ns/1ps

module audio_sequencer import memory_pkg::*; #(
	parameter int SLOT_WORDS = SLOT_WORDS_DEFAULT
) (
	input  logic        clk,
	input  logic        pb_reset,
	cmd_if.sequencer    cmd,
	// RAM word port
	output ram_addr_t   ram_address,
	output sample_t     ram_write_data,
	output logic        ram_write_enable,
	output logic        ram_read_request,
	output logic        ram_read_ack,
	input  sample_t     ram_read_data,
	input  logic        ram_data_present,
	input  logic        ram_ready,
	// Sample streams
	input  sample_t     sample_in,
	input  logic        sample_valid,
	output sample_t     sample_out,
	output logic        sample_out_valid,
	output slot_flags_t message_flags
);

	seq_state_e state;
	// Slot bounds for the command on cmd_if
	ram_addr_t slot_base;
	ram_addr_t slot_last;
	// Bounds and slot of the running transfer
	ram_addr_t addr_last;
	slot_t cur_slot;
	// Read left outstanding by a stop, still to be acknowledged
	logic drain;
	logic drain_ack;
	logic start_any;

	// Base is slot times slot size, limit is the last word of the slot
	assign slot_base = ram_addr_t'(cmd.slot) * ram_addr_t'(SLOT_WORDS);
	assign slot_last = slot_base + ram_addr_t'(SLOT_WORDS - 1);
	assign start_any = cmd.play_start || cmd.rec_start;

	////////////////////////////////////////
	// Port outputs decoded from state
	////////////////////////////////////////
	assign ram_read_request = (state == READ_REQ);
	assign ram_read_ack = (state == READ_ACK) || drain_ack;
	// Only real playback acks carry a sample
	assign sample_out_valid = (state == READ_ACK);
	// Write goes out in the first cycle the RAM is ready
	assign ram_write_enable = (state == REC_WRITE) && ram_ready;

	////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			state <= IDLE;
			ram_address <= '0;
			message_flags <= '0;
		end else begin
			case (state)
				IDLE: begin
					// New starts wait until a dropped read is acknowledged
					if (cmd.play_start && !drain) begin
						ram_address <= slot_base;
						state <= READ_REQ;
					end else if (cmd.rec_start && !drain) begin
						ram_address <= slot_base;
						state <= REC_WAIT;
					end
				end
				// Request is a single cycle
				READ_REQ: state <= READ_WAIT;
				READ_WAIT: begin
					if (ram_data_present)
						state <= READ_ACK;
				end
				READ_ACK: begin
					// Last word of the slot ends playback
					if (ram_address == addr_last) begin
						state <= IDLE;
					end else begin
						ram_address <= ram_address + ram_addr_t'(1);
						state <= READ_REQ;
					end
				end
				REC_WAIT: begin
					if (sample_valid)
						state <= REC_WRITE;
				end
				REC_WRITE: begin
					// Sample stays pending while the RAM is busy
					if (ram_ready) begin
						message_flags[cur_slot] <= 1'b1;
						if (ram_address == addr_last) begin
							state <= IDLE;
						end else begin
							ram_address <= ram_address + ram_addr_t'(1);
							state <= REC_WAIT;
						end
					end
				end
				default: state <= IDLE;
			endcase
			// Stop wins over every transition
			if (cmd.stop)
				state <= IDLE;
		end
	end

	// Payload captures
	always_ff @(posedge clk) begin
		if ((state == IDLE) && start_any) begin
			cur_slot <= cmd.slot;
			addr_last <= slot_last;
		end
		if ((state == READ_WAIT) && ram_data_present)
			sample_out <= ram_read_data;
		// Samples arriving in REC_WRITE are dropped here
		if ((state == REC_WAIT) && sample_valid)
			ram_write_data <= sample_in;
	end

	////////////////////////////////////////
	// Ack for reads cut off by stop
	////////////////////////////////////////
	// RAM holds data_present until acked, so this always sees it
	always_ff @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			drain <= 1'b0;
			drain_ack <= 1'b0;
		end else begin
			drain_ack <= drain && ram_data_present;
			if (cmd.stop && ((state == READ_REQ) || (state == READ_WAIT)))
				drain <= 1'b1;
			else if (drain && ram_data_present)
				drain <= 1'b0;
		end
	end

endmodule

// ==== verilog/controller_top.sv ====
`timescale 1ns/1ps

module controller_top import menu_pkg::*, memory_pkg::*; #(
	parameter int SLOT_WORDS = SLOT_WORDS_DEFAULT
) (
	input  logic        clk,
	input  logic        pb_reset,
	// Processor port bus
	input  port_t       port_id,
	input  port_t       out_port,
	input  logic        write_strobe,
	output port_t       in_port,
	// Front panel
	input  logic [5:0]  switches,
	input  logic        select,
	input  logic        back,
	input  logic        pause_play,
	output volume_t     volume_level,
	// External word RAM
	output ram_addr_t   ram_address,
	output sample_t     ram_write_data,
	output logic        ram_write_enable,
	output logic        ram_read_request,
	output logic        ram_read_ack,
	input  sample_t     ram_read_data,
	input  logic        ram_data_present,
	input  logic        ram_ready,
	// Audio sample streams
	input  sample_t     sample_in,
	input  logic        sample_valid,
	output sample_t     sample_out,
	output logic        sample_out_valid,
	output slot_flags_t message_flags
);

	// Decoder to registers
	pb_write_if wr_bus ();
	// Registers to sequencer
	cmd_if cmd_bus ();

	port_decoder u_port_decoder (
		.clk           (clk),
		.pb_reset      (pb_reset),
		.port_id       (port_id),
		.out_port      (out_port),
		.write_strobe  (write_strobe),
		.in_port       (in_port),
		.switches      (switches),
		.select        (select),
		.back          (back),
		.pause_play    (pause_play),
		.message_flags (message_flags),
		.wr            (wr_bus.decoder)
	);

	menu_registers u_menu_registers (
		.clk          (clk),
		.pb_reset     (pb_reset),
		.wr           (wr_bus.registers),
		.volume_level (volume_level),
		.cmd          (cmd_bus.registers)
	);

	// Slot size comes from the top so simulation can shrink it
	audio_sequencer #(
		.SLOT_WORDS (SLOT_WORDS)
	) u_audio_sequencer (
		.clk              (clk),
		.pb_reset         (pb_reset),
		.cmd              (cmd_bus.sequencer),
		.ram_address      (ram_address),
		.ram_write_data   (ram_write_data),
		.ram_write_enable (ram_write_enable),
		.ram_read_request (ram_read_request),
		.ram_read_ack     (ram_read_ack),
		.ram_read_data    (ram_read_data),
		.ram_data_present (ram_data_present),
		.ram_ready        (ram_ready),
		.sample_in        (sample_in),
		.sample_valid     (sample_valid),
		.sample_out       (sample_out),
		.sample_out_valid (sample_out_valid),
		.message_flags    (message_flags)
	);

endmodule

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps

// Free running clock and power-on reset for the testbench
module clock_gen #(
	parameter real PERIOD_NS = 100.0,
	parameter int  RESET_CYCLES = 16
) (
	output logic clk,
	output logic pb_reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// Reset drops on a rising edge after the hold time
	initial begin
		pb_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		pb_reset <= 1'b0;
	end

endmodule

// ==== tb/controller_properties.sv ====
`timescale 1ns/1ps

// Handshake rules on the RAM port of controller_top
module controller_properties (
	input logic      clk,
	input logic      pb_reset,
	input logic      ram_read_request,
	input logic      ram_read_ack,
	input logic      ram_data_present,
	input logic      ram_write_enable,
	input logic      ram_ready,
	input logic      sample_out_valid
);

	////////////////////////////////////////
	// Read handshake
	////////////////////////////////////////

	// Request is a one cycle pulse
	request_pulse: assert property (@(posedge clk) disable iff (pb_reset)
		ram_read_request |=> !ram_read_request)
		else $error("read request held longer than one cycle");

	// Ack only in the cycle after data was present
	ack_after_data: assert property (@(posedge clk) disable iff (pb_reset)
		ram_read_ack |-> $past(ram_data_present))
		else $error("read ack without data present the cycle before");

	// Every data present gets its ack, one cycle later when a stop cut the read off
	ack_follows_data: assert property (@(posedge clk) disable iff (pb_reset)
		$rose(ram_data_present) |=> ##[0:1] ram_read_ack)
		else $error("data present never acknowledged");

	// Ack is a one cycle pulse
	ack_pulse: assert property (@(posedge clk) disable iff (pb_reset)
		ram_read_ack |=> !ram_read_ack)
		else $error("read ack held longer than one cycle");

	// Every output sample comes with an ack
	sample_with_ack: assert property (@(posedge clk) disable iff (pb_reset)
		sample_out_valid |-> ram_read_ack)
		else $error("sample_out_valid without read ack");

	////////////////////////////////////////
	// Write handshake
	////////////////////////////////////////

	// Writes only go out while the RAM is ready
	write_when_ready: assert property (@(posedge clk) disable iff (pb_reset)
		ram_write_enable |-> ram_ready)
		else $error("write enable while RAM not ready");

	// No read and write in the same cycle
	no_mixed_access: assert property (@(posedge clk) disable iff (pb_reset)
		!(ram_write_enable && ram_read_request))
		else $error("read request and write enable together");

endmodule

// ==== tb/tb_controller.sv ====
`timescale 1ns/1ps

module tb_controller import menu_pkg::*, memory_pkg::*; ();

	localparam int SLOT = 8;
	localparam int N_TESTS = 5;
	localparam int WAIT_MAX = 60;

	logic clk;
	logic pb_reset;
	port_t port_id;
	port_t out_port;
	logic write_strobe;
	port_t in_port;
	logic [5:0] switches;
	logic select;
	logic back;
	logic pause_play;
	volume_t volume_level;
	ram_addr_t ram_address;
	sample_t ram_write_data;
	logic ram_write_enable;
	logic ram_read_request;
	logic ram_read_ack;
	sample_t ram_read_data;
	logic ram_data_present;
	logic ram_ready;
	sample_t sample_in;
	logic sample_valid;
	sample_t sample_out;
	logic sample_out_valid;
	slot_flags_t message_flags;

	int errors;
	int tests_failed;
	sample_t recorded[SLOT];

	clock_gen #(.PERIOD_NS(100.0), .RESET_CYCLES(16)) u_clock_gen (
		.clk      (clk),
		.pb_reset (pb_reset)
	);

	controller_top #(.SLOT_WORDS(SLOT)) u_controller_top (.*);

	bind controller_top controller_properties u_controller_properties (
		.clk              (clk),
		.pb_reset         (pb_reset),
		.ram_read_request (ram_read_request),
		.ram_read_ack     (ram_read_ack),
		.ram_data_present (ram_data_present),
		.ram_write_enable (ram_write_enable),
		.ram_ready        (ram_ready),
		.sample_out_valid (sample_out_valid)
	);

	////////////////////////////////////////
	// RAM model
	////////////////////////////////////////
	sample_t mem[64];
	logic rd_busy;
	ram_addr_t rd_addr;
	int rd_delay;

	always @(posedge clk or posedge pb_reset) begin
		if (pb_reset) begin
			ram_data_present <= 1'b0;
			ram_read_data <= '0;
			ram_ready <= 1'b0;
			rd_busy <= 1'b0;
			rd_delay <= 0;
		end else begin
			// Latch the request, answer 1 to 4 cycles later
			if (ram_read_request && !rd_busy) begin
				rd_busy <= 1'b1;
				rd_addr <= ram_address;
				rd_delay <= 1 + ($urandom % 4);
			end else if (rd_busy && !ram_data_present) begin
				if (rd_delay <= 1) begin
					ram_data_present <= 1'b1;
					ram_read_data <= mem[rd_addr[5:0]];
				end else begin
					rd_delay <= rd_delay - 1;
				end
			end else if (ram_data_present && ram_read_ack) begin
				// Data stays until acked
				ram_data_present <= 1'b0;
				rd_busy <= 1'b0;
			end
			if (ram_write_enable)
				mem[ram_address[5:0]] <= ram_write_data;
			ram_ready <= 1'($urandom % 2);
		end
	end

	////////////////////////////////////////
	// Bus and stream tasks
	////////////////////////////////////////

	// One processor write, returns at the edge that consumes it
	task automatic pb_write(input port_t p, input port_t d);
		@(posedge clk);
		port_id <= p;
		out_port <= d;
		write_strobe <= 1'b1;
		@(posedge clk);
		write_strobe <= 1'b0;
	endtask

	task automatic pulse_sample(input sample_t s);
		@(posedge clk);
		sample_in <= s;
		sample_valid <= 1'b1;
		@(posedge clk);
		sample_valid <= 1'b0;
	endtask

	// Wait for a RAM write, give up after WAIT_MAX cycles
	task automatic wait_write(output bit seen, output ram_addr_t a, output sample_t d);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_MAX; n++) begin
			@(negedge clk);
			if (ram_write_enable) begin
				seen = 1'b1;
				a = ram_address;
				d = ram_write_data;
				break;
			end
		end
	endtask

	task automatic wait_sample(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_MAX; n++) begin
			@(negedge clk);
			if (sample_out_valid) begin
				seen = 1'b1;
				break;
			end
		end
	endtask

	// Counts activity on a strobe over a window
	task automatic count_high(input int cycles, input bit wr_side, output int hits);
		int n;
		hits = 0;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (wr_side ? ram_write_enable : ram_read_request)
				hits++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////
	initial begin
		#(N_TESTS * SLOT * 40 * 100);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	initial begin
		int e0;
		int k;
		int hits;
		bit seen;
		ram_addr_t a;
		ram_addr_t prev;
		sample_t d;
		port_t exp;
		volume_t v;
		port_t ports[7];

		void'($urandom(97));
		errors = 0;
		tests_failed = 0;
		port_id = '0;
		out_port = '0;
		write_strobe = 1'b0;
		switches = '0;
		select = 1'b0;
		back = 1'b0;
		pause_play = 1'b0;
		sample_in = '0;
		sample_valid = 1'b0;
		// Fill tied to every address bit
		for (k = 0; k < 64; k++)
			mem[k] = 16'hA500 ^ sample_t'(k * 16'h0101);
		ports = '{8'h00, 8'h08, 8'h09, 8'h0A, 8'h0B, 8'h07, 8'hFF};

		@(negedge pb_reset);
		repeat (2) @(posedge clk);

		// Read ports, random panel inputs
		e0 = errors;
		for (k = 0; k < 7; k++) begin
			@(posedge clk);
			switches <= 6'($urandom);
			select <= 1'($urandom);
			back <= 1'($urandom);
			pause_play <= 1'($urandom);
			port_id <= ports[k];
			@(posedge clk);
			@(negedge clk);
			case (ports[k])
				8'h00: exp = {2'b00, switches};
				8'h08: exp = {7'd0, select};
				8'h09: exp = {7'd0, back};
				8'h0A: exp = {7'd0, pause_play};
				// Nothing recorded yet
				default: exp = 8'h00;
			endcase
			assert (in_port == exp) else begin
				$display("** Error in_port = %h, expected %h, port %h", in_port, exp, ports[k]);
				errors++;
			end
		end
		end_test("read ports", e0);

		// Volume, stepping and saturation
		e0 = errors;
		v = 4'd1;
		pb_write(8'h0B, 8'h05);
		for (k = 0; k < 32; k++) begin
			pb_write(8'h04, (k < 16) ? 8'h01 : 8'h02);
			if (k < 16)
				v = (v == 4'd15) ? v : v + 4'd1;
			else
				v = (v == 4'd1) ? v : v - 4'd1;
			@(negedge clk);
			assert (volume_level == v) else begin
				$display("** Error volume_level = %h, expected %h", volume_level, v);
				errors++;
			end
		end
		// Other mode, level must hold
		pb_write(8'h0B, 8'h00);
		pb_write(8'h04, 8'h01);
		@(negedge clk);
		assert (volume_level == v) else begin
			$display("** Error volume_level = %h, expected %h", volume_level, v);
			errors++;
		end
		end_test("volume", e0);

		// Recording, code 3 is slot index 2, words 16 to 23
		e0 = errors;
		pb_write(8'h0B, 8'h02);
		pb_write(8'h05, 8'h03);
		repeat (3) @(posedge clk);
		prev = ram_addr_t'(2 * SLOT - 1);
		for (k = 0; k < SLOT; k++) begin
			recorded[k] = sample_t'($urandom);
			pulse_sample(recorded[k]);
			wait_write(seen, a, d);
			assert (seen) else begin
				$display("No RAM write after sample %0d", k);
				errors++;
			end
			assert (a == prev + ram_addr_t'(1) && a <= ram_addr_t'(3 * SLOT - 1)) else begin
				$display("** Error ram_address = %h, expected %h", a, prev + ram_addr_t'(1));
				errors++;
			end
			assert (d == recorded[k]) else begin
				$display("** Error ram_write_data = %h, expected %h", d, recorded[k]);
				errors++;
			end
			prev = a;
		end
		// Slot is full, a further sample must not be written
		pulse_sample(16'h1234);
		count_high(20, 1'b1, hits);
		assert (hits == 0) else begin
			$display("Write past the end of the slot");
			errors++;
		end
		@(posedge clk);
		port_id <= 8'h0B;
		@(posedge clk);
		@(negedge clk);
		assert (in_port == 8'h04) else begin
			$display("** Error in_port = %h, expected %h", in_port, 8'h04);
			errors++;
		end
		// Only slot 2 holds a recording
		assert (message_flags == 5'b00100) else begin
			$display("** Error message_flags = %h, expected %h", message_flags, 5'b00100);
			errors++;
		end
		end_test("recording", e0);

		// Playback of slot index 2
		e0 = errors;
		pb_write(8'h0B, 8'h01);
		pb_write(8'h0C, 8'h02);
		for (k = 0; k < SLOT; k++) begin
			wait_sample(seen);
			assert (seen) else begin
				$display("Playback stalled at sample %0d", k);
				errors++;
			end
			assert (sample_out == recorded[k]) else begin
				$display("** Error sample_out = %h, expected %h", sample_out, recorded[k]);
				errors++;
			end
		end
		count_high(30, 1'b0, hits);
		assert (hits == 0) else begin
			$display("Read request after the last slot word");
			errors++;
		end
		end_test("playback", e0);

		// Stop during playback and recording, commands in wrong mode
		e0 = errors;
		pb_write(8'h0C, 8'h02);
		wait_sample(seen);
		wait_sample(seen);
		pb_write(8'h0B, 8'h00);
		// Outstanding read drains within the RAM delay
		repeat (10) @(posedge clk);
		count_high(30, 1'b0, hits);
		assert (hits == 0 && !ram_data_present) else begin
			$display("Playback did not stop after a state write");
			errors++;
		end
		pb_write(8'h0B, 8'h02);
		pb_write(8'h05, 8'h01);
		repeat (3) @(posedge clk);
		pulse_sample(16'hBEEF);
		wait_write(seen, a, d);
		pb_write(8'h05, 8'h00);
		repeat (3) @(posedge clk);
		pulse_sample(16'hCAFE);
		count_high(20, 1'b1, hits);
		assert (hits == 0) else begin
			$display("Recording did not stop after a stop write");
			errors++;
		end
		// MAIN mode, play and record commands are ignored
		pb_write(8'h0B, 8'h00);
		pb_write(8'h0C, 8'h00);
		count_high(20, 1'b0, hits);
		assert (hits == 0) else begin
			$display("Play started outside PLAY mode");
			errors++;
		end
		pb_write(8'h05, 8'h01);
		repeat (3) @(posedge clk);
		pulse_sample(16'h5A5A);
		count_high(20, 1'b1, hits);
		assert (hits == 0) else begin
			$display("Recording started outside RECORD mode");
			errors++;
		end
		end_test("stop", e0);

		$display("Tests %0d, failed %0d, errors %0d", N_TESTS, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/menu_pkg.sv
verilog/memory_pkg.sv
verilog/pb_write_if.sv
verilog/cmd_if.sv
verilog/port_decoder.sv
verilog/menu_registers.sv
verilog/audio_sequencer.sv
verilog/controller_top.sv
tb/clock_gen.sv
tb/controller_properties.sv
tb/tb_controller.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_controller
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
